// ==== include/sprite_params.svh ====
`ifndef SPRITE_PARAMS_SVH
`define SPRITE_PARAMS_SVH

// Number of sprite records held in sprite RAM
`define SPR_COUNT 32

// Sprites are square, this many pixels on a side
`define SPR_SIZE 16

// Bytes per sprite record
`define SPR_RECORD_BYTES 4

// Visible part of a line slot, cleared and rendered each line
`define LINE_PIXELS 352

// Address range of one line buffer slot
`define SLOT_DEPTH 512

// Horizontal offset between hcnt and the buffer read address
`define SPR_X_OFFSET 16

// The engine renders this many lines ahead of vcnt
`define SPR_Y_OFFSET 17

`endif

// ==== rtl/sprite_pkg.sv ====
package sprite_pkg;

	// Sprite number, one of SPR_COUNT records
	typedef logic [4:0] sprite_index_t;

	// Position within one line buffer slot
	typedef logic [8:0] line_addr_t;

	// Byte address into sprite RAM (32 records of 4 bytes)
	typedef logic [6:0] sprite_ram_addr_t;

	// Byte address into sprite ROM, image:row:column
	typedef logic [13:0] sprite_rom_addr_t;

	// Palette ROM word address, always even
	typedef logic [5:0] pal_addr_t;

	// Stored pixel
	// bits 4:0 red, 9:5 green, 14:10 blue, 15 alpha
	typedef logic [15:0] pixel_t;

	// One expanded 8-bit colour channel
	typedef logic [7:0] channel_t;

	// Image number inside sprite ROM
	typedef logic [5:0] image_index_t;

	// Row within a sprite
	typedef logic [3:0] row_t;

	// Vertical coordinate of a line or a sprite
	typedef logic [11:0] line_y_t;

	// Widen a 5-bit colour field to 8 bits by repeating its top bits
	function automatic channel_t expand_channel(input logic [4:0] field);
		return {field, field[4:2]};
	endfunction

endpackage

// ==== rtl/sprite_scanner.sv ====
`timescale 1ns/100ps
`include "sprite_params.svh"

module sprite_scanner (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          hsync,
	input  logic [8:0]                    vcnt,
	input  logic [7:0]                    sprite_ram_data,
	input  logic                          clear_busy,
	input  logic                          row_done,
	output sprite_pkg::sprite_ram_addr_t  sprite_ram_addr,
	output logic                          swap,
	output logic                          render_busy,
	output logic                          start,
	output sprite_pkg::line_addr_t        sprite_x,
	output sprite_pkg::image_index_t      image,
	output sprite_pkg::row_t              row
);
	import sprite_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_CLEAR,
		S_READ,
		S_CHECK,
		S_FETCH
	} state_t;

	state_t        state;
	logic          hsync_q;
	logic          line_start;
	sprite_index_t spr_index;
	logic [2:0]    rd_cnt;
	logic          spr_en;
	line_y_t       spr_y;
	line_y_t       active_y;
	logic [12:0]   y_diff;
	logic          hit;
	logic          last_sprite;
	logic          advance;

	assign line_start = (state == S_IDLE) && hsync && !hsync_q;

	// Extra top bit catches an active line above the sprite
	assign y_diff = {1'b0, active_y} - {1'b0, spr_y};
	assign hit = spr_en && !y_diff[12] && (y_diff[11:0] < 12'(`SPR_SIZE));
	assign last_sprite = (spr_index == sprite_index_t'(`SPR_COUNT - 1));
	assign advance = ((state == S_CHECK) && !hit) || ((state == S_FETCH) && row_done);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state           <= S_IDLE;
			hsync_q         <= 1'b0;
			spr_index       <= '0;
			rd_cnt          <= '0;
			swap            <= 1'b0;
			start           <= 1'b0;
			render_busy     <= 1'b0;
			sprite_ram_addr <= '0;
		end
		else
		begin
			hsync_q <= hsync;
			swap    <= 1'b0;
			start   <= 1'b0;

			case (state)
				S_IDLE:
				begin
					if (line_start)
					begin
						swap        <= 1'b1;
						render_busy <= 1'b1;
						spr_index   <= '0;
						state       <= S_CLEAR;
					end
				end

				// clear_busy only rises the cycle after the swap pulse
				S_CLEAR:
				begin
					if (!swap && !clear_busy)
					begin
						sprite_ram_addr <= '0;
						rd_cnt          <= '0;
						state           <= S_READ;
					end
				end

				// Bytes arrive two edges after their address, so the address runs ahead
				S_READ:
				begin
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt < 3'd3)
					begin
						sprite_ram_addr <= sprite_ram_addr + 1'b1;
					end
					if (rd_cnt == 3'd4)
					begin
						state <= S_CHECK;
					end
				end

				S_CHECK:
				begin
					if (hit)
					begin
						start <= 1'b1;
						state <= S_FETCH;
					end
				end

				S_FETCH:
				begin
				end

				default:
				begin
					state <= S_IDLE;
				end
			endcase

			// Move on after a miss or a finished row
			if (advance)
			begin
				if (last_sprite)
				begin
					render_busy     <= 1'b0;
					sprite_ram_addr <= '0;
					state           <= S_IDLE;
				end
				else
				begin
					spr_index       <= spr_index + 1'b1;
					sprite_ram_addr <= sprite_ram_addr_t'((spr_index + 1) * `SPR_RECORD_BYTES);
					rd_cnt          <= '0;
					state           <= S_READ;
				end
			end
		end
	end

	// Record fields and the line being built
	always_ff @(posedge clk)
	begin
		if (line_start)
		begin
			active_y <= line_y_t'(vcnt) + line_y_t'(`SPR_Y_OFFSET);
		end
		if (state == S_READ)
		begin
			case (rd_cnt)
				3'd1:
				begin
					spr_en      <= sprite_ram_data[7];
					spr_y[11:8] <= sprite_ram_data[3:0];
				end
				3'd2: spr_y[7:0] <= sprite_ram_data;
				3'd3:
				begin
					image       <= sprite_ram_data[7:2];
					sprite_x[8] <= sprite_ram_data[0];
				end
				3'd4: sprite_x[7:0] <= sprite_ram_data;
				default:
				begin
				end
			endcase
		end
		if (state == S_CHECK)
		begin
			row <= y_diff[3:0];
		end
	end

endmodule

// ==== rtl/sprite_pixel_fetch.sv ====
`timescale 1ns/100ps
`include "sprite_params.svh"

module sprite_pixel_fetch (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          start,
	input  sprite_pkg::line_addr_t        sprite_x,
	input  sprite_pkg::image_index_t      image,
	input  sprite_pkg::row_t              row,
	input  logic [7:0]                    sprite_rom_data,
	input  sprite_pkg::pixel_t            palette_data,
	output sprite_pkg::sprite_rom_addr_t  sprite_rom_addr,
	output sprite_pkg::pal_addr_t         palette_addr,
	output logic                          wr_en,
	output sprite_pkg::line_addr_t        wr_addr,
	output sprite_pkg::pixel_t            wr_data,
	output logic                          row_done
);
	import sprite_pkg::*;

	logic       issuing;
	line_addr_t base_x;
	logic [9:0] col_pos;

	// Column tags behind the ROM address
	// 1: ROM data in flight, 2: palette address out, 3: palette data back
	logic [3:1] vld;
	logic [9:0] pos [1:3];

	// One bit wider than a slot address so a sprite running off the end is not wrapped
	assign col_pos = {1'b0, base_x} + 10'(sprite_rom_addr[3:0]);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			issuing         <= 1'b0;
			sprite_rom_addr <= '0;
			vld             <= '0;
			palette_addr    <= '0;
			wr_en           <= 1'b0;
			wr_addr         <= '0;
			row_done        <= 1'b0;
		end
		else
		begin
			// Stage 1, one ROM address per cycle for columns 0 to 15
			if (start)
			begin
				sprite_rom_addr <= {image, row, 4'd0};
				issuing         <= 1'b1;
			end
			else if (issuing)
			begin
				if (sprite_rom_addr[3:0] == 4'(`SPR_SIZE - 1))
				begin
					issuing <= 1'b0;
				end
				else
				begin
					sprite_rom_addr <= sprite_rom_addr + 1'b1;
				end
			end

			vld <= {vld[2:1], issuing};

			// Stage 2, palette words are two bytes apart
			if (vld[1])
			begin
				palette_addr <= {sprite_rom_data[4:0], 1'b0};
			end

			// Stage 3, transparent and off-line pixels are dropped
			wr_en <= vld[3] && palette_data[15] && (pos[3] < 10'(`LINE_PIXELS));
			if (vld[3])
			begin
				wr_addr <= pos[3][8:0];
			end

			// Last column leaves stage 3 with nothing behind it
			row_done <= vld[3] && !vld[2];
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			base_x <= sprite_x;
		end
		pos[1] <= col_pos;
		pos[2] <= pos[1];
		pos[3] <= pos[2];
		if (vld[3])
		begin
			wr_data <= palette_data;
		end
	end

endmodule

// ==== rtl/sprite_line_buffer.sv ====
`timescale 1ns/100ps
`include "sprite_params.svh"

module sprite_line_buffer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    swap,
	input  logic                    wr_en,
	input  sprite_pkg::line_addr_t  wr_addr,
	input  sprite_pkg::pixel_t      wr_data,
	input  logic [8:0]              hcnt,
	output logic                    clear_busy,
	output sprite_pkg::channel_t    spr_r,
	output sprite_pkg::channel_t    spr_g,
	output sprite_pkg::channel_t    spr_b,
	output logic                    spr_a
);
	import sprite_pkg::*;

	// Two slots, selected by the top address bit
	pixel_t     mem [2*`SLOT_DEPTH];

	logic       rd_slot;
	logic       wr_slot;
	line_addr_t clr_addr;
	line_addr_t rd_addr;
	pixel_t     rd_data;

	assign rd_addr = line_addr_t'(hcnt + `SPR_X_OFFSET);

	// Slot control and the self-clear counter
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_slot    <= 1'b0;
			wr_slot    <= 1'b1;
			clear_busy <= 1'b0;
			clr_addr   <= '0;
		end
		else if (swap)
		begin
			rd_slot    <= ~rd_slot;
			wr_slot    <= ~wr_slot;
			clear_busy <= 1'b1;
			clr_addr   <= '0;
		end
		else if (clear_busy)
		begin
			if (clr_addr == line_addr_t'(`LINE_PIXELS - 1))
			begin
				clear_busy <= 1'b0;
			end
			else
			begin
				clr_addr <= clr_addr + 1'b1;
			end
		end
	end

	// Single write port, clearing wins over sprite pixels
	always_ff @(posedge clk)
	begin
		if (clear_busy)
		begin
			mem[{wr_slot, clr_addr}] <= '0;
		end
		else if (wr_en)
		begin
			mem[{wr_slot, wr_addr}] <= wr_data;
		end
	end

	// Read port follows hcnt on the display slot
	always_ff @(posedge clk)
	begin
		rd_data <= mem[{rd_slot, rd_addr}];
	end

	// RGB555 to 8 bits per channel
	assign spr_r = expand_channel(rd_data[4:0]);
	assign spr_g = expand_channel(rd_data[9:5]);
	assign spr_b = expand_channel(rd_data[14:10]);
	assign spr_a = rd_data[15];

endmodule

// ==== rtl/sprite_engine_top.sv ====
`timescale 1ns/100ps

module sprite_engine_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          hsync,
	input  logic [8:0]                    vcnt,
	input  logic [8:0]                    hcnt,
	output sprite_pkg::sprite_ram_addr_t  sprite_ram_addr,
	input  logic [7:0]                    sprite_ram_data,
	output sprite_pkg::sprite_rom_addr_t  sprite_rom_addr,
	input  logic [7:0]                    sprite_rom_data,
	output sprite_pkg::pal_addr_t         palette_addr,
	input  sprite_pkg::pixel_t            palette_data,
	output sprite_pkg::channel_t          spr_r,
	output sprite_pkg::channel_t          spr_g,
	output sprite_pkg::channel_t          spr_b,
	output logic                          spr_a,
	output logic                          render_busy
);
	import sprite_pkg::*;

	// Scanner to line buffer
	logic         swap;
	logic         clear_busy;

	// Scanner to fetcher
	logic         start;
	logic         row_done;
	line_addr_t   sprite_x;
	image_index_t image;
	row_t         row;

	// Fetcher to line buffer
	logic         wr_en;
	line_addr_t   wr_addr;
	pixel_t       wr_data;

	sprite_scanner i_scanner (
		.clk             (clk),
		.rst_n           (rst_n),
		.hsync           (hsync),
		.vcnt            (vcnt),
		.sprite_ram_data (sprite_ram_data),
		.clear_busy      (clear_busy),
		.row_done        (row_done),
		.sprite_ram_addr (sprite_ram_addr),
		.swap            (swap),
		.render_busy     (render_busy),
		.start           (start),
		.sprite_x        (sprite_x),
		.image           (image),
		.row             (row)
	);

	sprite_pixel_fetch i_fetch (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (start),
		.sprite_x        (sprite_x),
		.image           (image),
		.row             (row),
		.sprite_rom_data (sprite_rom_data),
		.palette_data    (palette_data),
		.sprite_rom_addr (sprite_rom_addr),
		.palette_addr    (palette_addr),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data),
		.row_done        (row_done)
	);

	sprite_line_buffer i_line_buffer (
		.clk        (clk),
		.rst_n      (rst_n),
		.swap       (swap),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.hcnt       (hcnt),
		.clear_busy (clear_busy),
		.spr_r      (spr_r),
		.spr_g      (spr_g),
		.spr_b      (spr_b),
		.spr_a      (spr_a)
	);

endmodule

// ==== bench/sprite_engine_asserts.sv ====
`timescale 1ns/100ps
`include "sprite_params.svh"

module sprite_engine_asserts (
	input logic clk,
	input logic rst_n,
	input logic render_busy,
	input logic wr_en,
	input logic start,
	input logic clear_busy
);
	localparam int MAX_RENDER_CYCLES = 3600;

	logic [11:0] busy_cycles;

	// Length of the current render, zero while idle
	always_ff @(posedge clk)
	begin
		if (!rst_n || !render_busy)
		begin
			busy_cycles <= '0;
		end
		else
		begin
			busy_cycles <= busy_cycles + 1'b1;
		end
	end

	// Sprite pixels only land in the buffer while a line is being built
	write_in_render: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> render_busy)
		else $error("Line buffer write while render_busy is low");

	// A sprite write during the clear would be lost under the clear writes
	write_after_clear: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> !clear_busy)
		else $error("Line buffer write while the slot is still being cleared");

	// The scanner holds the fetcher idle until the new slot is clean
	start_after_clear: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !clear_busy)
		else $error("Row fetch started while the slot is still being cleared");

	render_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		render_busy |-> (busy_cycles < 12'(MAX_RENDER_CYCLES)))
		else $error("Line render ran longer than its worst case");

endmodule

bind sprite_engine_top sprite_engine_asserts i_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.render_busy (render_busy),
	.wr_en       (wr_en),
	.start       (start),
	.clear_busy  (clear_busy)
);

// ==== bench/sprite_engine_tb.sv ====
`timescale 1ns/100ps
`include "sprite_params.svh"

module sprite_engine_tb;
	import sprite_pkg::*;

	// Each render pass spans two lines
	localparam int RENDER_PASSES = 15;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = RENDER_PASSES * 2 * 4000 + RESET_CYCLES;

	logic             clk = 1'b0;
	logic             rst_n;
	logic             hsync;
	logic [8:0]       vcnt;
	logic [8:0]       hcnt;
	sprite_ram_addr_t sprite_ram_addr;
	logic [7:0]       sprite_ram_data = '0;
	sprite_rom_addr_t sprite_rom_addr;
	logic [7:0]       sprite_rom_data = '0;
	pal_addr_t        palette_addr;
	pixel_t           palette_data = '0;
	channel_t         spr_r;
	channel_t         spr_g;
	channel_t         spr_b;
	logic             spr_a;
	logic             render_busy;
	int               cycle_count = 0;

	// External memories
	logic [7:0] sprite_ram [`SPR_COUNT * `SPR_RECORD_BYTES];
	logic [7:0] sprite_rom [16384];
	pixel_t     palette [64];

	// Line the model expects to see displayed
	pixel_t     expected [`LINE_PIXELS];

	sprite_engine_top i_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.hsync           (hsync),
		.vcnt            (vcnt),
		.hcnt            (hcnt),
		.sprite_ram_addr (sprite_ram_addr),
		.sprite_ram_data (sprite_ram_data),
		.sprite_rom_addr (sprite_rom_addr),
		.sprite_rom_data (sprite_rom_data),
		.palette_addr    (palette_addr),
		.palette_data    (palette_data),
		.spr_r           (spr_r),
		.spr_g           (spr_g),
		.spr_b           (spr_b),
		.spr_a           (spr_a),
		.render_busy     (render_busy)
	);

	always #20 clk = ~clk;

	// Registered-address memories, data one edge after the address
	always @(posedge clk)
	begin
		sprite_ram_data <= sprite_ram[sprite_ram_addr];
		sprite_rom_data <= sprite_rom[sprite_rom_addr];
		palette_data    <= palette[palette_addr];
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic compare_channel(input string test_name, input string what, input int col,
			input channel_t exp, input channel_t act);
		if (act !== exp)
		begin
			$display("Error: %s %s at column %0d expected %h actual %h",
				test_name, what, col, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_alpha(input string test_name, input int col,
			input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Error: %s spr_a at column %0d expected %b actual %b",
				test_name, col, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_busy(input string test_name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Error: %s render_busy expected %b actual %b", test_name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_addr(input string test_name, input string what,
			input sprite_rom_addr_t exp, input sprite_rom_addr_t act);
		if (act !== exp)
		begin
			$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
			stop_run();
		end
	endtask

	// 5-bit field scaled to 8 bits, top bits fill the low end
	function automatic channel_t widen5(input logic [4:0] f);
		return channel_t'(int'(f) * 8 + int'(f) / 4);
	endfunction

	task automatic clear_sprites();
		for (int a = 0; a < `SPR_COUNT * `SPR_RECORD_BYTES; a++)
		begin
			sprite_ram[a] = '0;
		end
	endtask

	task automatic set_sprite(input int idx, input logic en, input line_y_t y,
			input line_addr_t x, input image_index_t img);
		sprite_ram[4 * idx]     = {en, 3'b000, y[11:8]};
		sprite_ram[4 * idx + 1] = y[7:0];
		sprite_ram[4 * idx + 2] = {img, 1'b0, x[8]};
		sprite_ram[4 * idx + 3] = x[7:0];
	endtask

	// Reference render of one line straight from the memory arrays
	task automatic build_expected(input int line);
		line_y_t      active;
		line_y_t      spr_y;
		line_addr_t   spr_x;
		image_index_t img;
		int           row;
		logic [4:0]   colour;
		pixel_t       pix;
		logic [9:0]   pos;
		for (int a = 0; a < `LINE_PIXELS; a++)
		begin
			expected[a] = '0;
		end
		active = line_y_t'(line + `SPR_Y_OFFSET);
		for (int i = 0; i < `SPR_COUNT; i++)
		begin
			spr_y = {sprite_ram[4 * i][3:0], sprite_ram[4 * i + 1]};
			img   = sprite_ram[4 * i + 2][7:2];
			spr_x = {sprite_ram[4 * i + 2][0], sprite_ram[4 * i + 3]};
			if (sprite_ram[4 * i][7] && active >= spr_y &&
					(active - spr_y) < line_y_t'(`SPR_SIZE))
			begin
				row = int'(active - spr_y);
				for (int c = 0; c < `SPR_SIZE; c++)
				begin
					colour = sprite_rom[int'(img) * 256 + row * 16 + c][4:0];
					pix    = palette[{colour, 1'b0}];
					pos    = 10'(spr_x) + 10'(c);
					if (pix[15] && pos < 10'(`LINE_PIXELS))
					begin
						expected[pos] = pix;
					end
				end
			end
		end
	endtask

	task automatic wait_idle();
		while (render_busy)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic pulse_hsync(input int line);
		@(posedge clk);
		#2;
		vcnt  = 9'(line);
		hsync = 1'b1;
		@(posedge clk);
		#2;
		hsync = 1'b0;
	endtask

	// Pixel for hcnt shows up one edge later, checked just after that edge
	task automatic sweep_and_check(input string test_name);
		pixel_t pix;
		for (int a = 0; a <= `LINE_PIXELS; a++)
		begin
			@(posedge clk);
			#2;
			if (a > 0)
			begin
				pix = expected[a - 1];
				compare_alpha(test_name, a - 1, pix[15], spr_a);
				compare_channel(test_name, "spr_r", a - 1, widen5(pix[4:0]), spr_r);
				compare_channel(test_name, "spr_g", a - 1, widen5(pix[9:5]), spr_g);
				compare_channel(test_name, "spr_b", a - 1, widen5(pix[14:10]), spr_b);
			end
			if (a < `LINE_PIXELS)
			begin
				hcnt = 9'(a - `SPR_X_OFFSET);
			end
		end
	endtask

	// Render a line, then display it on the next hsync
	task automatic render_and_check(input string test_name, input int line);
		string tag;
		tag = $sformatf("%s vcnt %0d", test_name, line);
		wait_idle();
		pulse_hsync(line);
		compare_busy(tag, 1'b1, render_busy);
		wait_idle();
		build_expected(line);
		pulse_hsync(line);
		sweep_and_check(tag);
	endtask

	task automatic test_reset_state();
		compare_busy("reset_state", 1'b0, render_busy);
		compare_addr("reset_state", "sprite_ram_addr", '0, sprite_rom_addr_t'(sprite_ram_addr));
		compare_addr("reset_state", "sprite_rom_addr", '0, sprite_rom_addr);
		compare_addr("reset_state", "palette_addr", '0, sprite_rom_addr_t'(palette_addr));
		clear_sprites();
		render_and_check("all_disabled", 0);
	endtask

	task automatic test_single_sprite();
		clear_sprites();
		for (int idx = 1; idx <= 16; idx++)
		begin
			palette[2 * idx] = {1'b1, 15'($urandom)};
		end
		// Upper three ROM bits are set and must be ignored
		for (int r = 0; r < `SPR_SIZE; r++)
		begin
			for (int c = 0; c < `SPR_SIZE; c++)
			begin
				sprite_rom[3 * 256 + r * 16 + c] = 8'(((r + c) % 16 + 1) | 32'he0);
			end
		end
		set_sprite(0, 1'b1, 12'd60, 9'd100, 6'd3);
		render_and_check("single_sprite", 42);
		render_and_check("single_sprite", 43);
		render_and_check("single_sprite", 50);
		render_and_check("single_sprite", 58);
		render_and_check("single_sprite", 59);
	endtask

	task automatic test_overlap_transparency();
		clear_sprites();
		palette[40] = 16'h7fff;
		palette[42] = {1'b1, 15'h001f};
		palette[44] = {1'b1, 15'h7c00};
		for (int r = 0; r < `SPR_SIZE; r++)
		begin
			for (int c = 0; c < `SPR_SIZE; c++)
			begin
				sprite_rom[7 * 256 + r * 16 + c] = 8'd21;
				sprite_rom[8 * 256 + r * 16 + c] = (c % 2 == 0) ? 8'd20 : 8'd22;
			end
		end
		set_sprite(2, 1'b1, 12'd100, 9'd50, 6'd7);
		set_sprite(5, 1'b1, 12'd100, 9'd58, 6'd8);
		set_sprite(9, 1'b1, 12'd100, 9'd200, 6'd8);
		render_and_check("overlap_transparency", 90);
	endtask

	task automatic test_stale_clear();
		clear_sprites();
		set_sprite(0, 1'b1, 12'd200, 9'd30, 6'd3);
		// Runs past the end of the visible line
		set_sprite(1, 1'b1, 12'd200, 9'd344, 6'd3);
		render_and_check("stale_clear", 183);
		render_and_check("stale_clear", 199);
	endtask

	task automatic test_random_records();
		line_y_t y;
		for (int a = 0; a < 16384; a++)
		begin
			sprite_rom[a] = 8'($urandom);
		end
		for (int a = 0; a < 64; a++)
		begin
			palette[a] = 16'($urandom);
		end
		for (int i = 0; i < `SPR_COUNT; i++)
		begin
			y = line_y_t'($urandom_range(0, 220));
			if (i % 8 == 7)
			begin
				y = line_y_t'($urandom);
			end
			sprite_ram[4 * i]     = {($urandom_range(0, 7) != 0), 3'($urandom), y[11:8]};
			sprite_ram[4 * i + 1] = y[7:0];
			sprite_ram[4 * i + 2] = 8'($urandom);
			sprite_ram[4 * i + 3] = 8'($urandom);
		end
		for (int n = 0; n < 6; n++)
		begin
			render_and_check("random_records", int'($urandom_range(0, 200)));
		end
	endtask

	initial
	begin
		void'($urandom(32'hbee7527d));
		rst_n = 1'b0;
		hsync = 1'b0;
		vcnt  = '0;
		hcnt  = '0;
		clear_sprites();
		for (int a = 0; a < 16384; a++)
		begin
			sprite_rom[a] = '0;
		end
		for (int a = 0; a < 64; a++)
		begin
			palette[a] = '0;
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;

		test_reset_state();
		test_single_sprite();
		test_overlap_transparency();
		test_stale_clear();
		test_random_records();

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+include
rtl/sprite_pkg.sv
rtl/sprite_scanner.sv
rtl/sprite_pixel_fetch.sv
rtl/sprite_line_buffer.sv
rtl/sprite_engine_top.sv
bench/sprite_engine_asserts.sv
bench/sprite_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sprite engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
	-f list.f \
	--top-module sprite_engine_tb \
	-o sprite_engine_sim

./obj_dir/sprite_engine_sim
